//--- logic/checkpoint_store.sv
`timescale 1ns/1ps

module checkpoint_store import rename_pkg::*; #(
    parameter int ARCH_REGS = DEFAULT_ARCH_REGS,
    parameter int WB_WIDTH  = DEFAULT_WB_WIDTH
) (
    input  logic                          clock,
    input  logic                          reset,

    // capture on branch, drop on resolve or mispredict
    input  logic                          take_i,
    input  logic                          release_i,

    // live map and free-list head
    input  phys_tag_t [ARCH_REGS-1:0]     snap_phys_i,
    input  logic      [ARCH_REGS-1:0]     snap_ready_i,
    input  fl_ptr_t                       head_ptr_i,

    // writeback ports
    input  logic      [WB_WIDTH-1:0]      wb_valid_i,
    input  phys_tag_t [WB_WIDTH-1:0]      wb_phys_i,

    // saved state for a restore
    output logic                          held_o,
    output phys_tag_t [ARCH_REGS-1:0]     saved_phys_o,
    output logic      [ARCH_REGS-1:0]     saved_ready_o,
    output fl_ptr_t                       saved_ptr_o
);

    cp_state_t                 state;
    phys_tag_t [ARCH_REGS-1:0] saved_phys;
    logic      [ARCH_REGS-1:0] saved_ready;
    fl_ptr_t                   saved_ptr;
    logic      [ARCH_REGS-1:0] wb_hit;

    // ======================================================================
    // state machine
    // ======================================================================

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= CP_EMPTY;
        end else begin
            case (state)
                CP_EMPTY: if (take_i)    state <= CP_HELD;
                CP_HELD:  if (release_i) state <= CP_EMPTY;
                default:                 state <= CP_EMPTY;
            endcase
        end
    end

    assign held_o = (state == CP_HELD);

    // ======================================================================
    // saved snapshot
    // ======================================================================

    // saved entries whose tag is written back this cycle
    always_comb begin
        wb_hit = '0;
        for (int j = 0; j < ARCH_REGS; j++) begin
            for (int k = 0; k < WB_WIDTH; k++) begin
                if (wb_valid_i[k] && (saved_phys[j] == wb_phys_i[k])) begin
                    wb_hit[j] = 1'b1;
                end
            end
        end
    end

    // capture only from empty, then keep ready bits in step with writebacks
    always_ff @(posedge clock) begin
        if ((state == CP_EMPTY) && take_i) begin
            saved_phys  <= snap_phys_i;
            saved_ready <= snap_ready_i;
            saved_ptr   <= head_ptr_i;
        end else if (state == CP_HELD) begin
            saved_ready <= saved_ready | wb_hit;
        end
    end

    // restore sees writebacks up to and including this cycle
    assign saved_phys_o  = saved_phys;
    assign saved_ready_o = saved_ready | wb_hit;
    assign saved_ptr_o   = saved_ptr;

endmodule

//--- logic/free_list.sv
`timescale 1ns/1ps

module free_list import rename_pkg::*; #(
    parameter int ARCH_REGS = DEFAULT_ARCH_REGS,
    parameter int PHYS_REGS = DEFAULT_PHYS_REGS
) (
    input  logic      clock,
    input  logic      reset,

    // allocation side
    input  logic      pop_i,
    output phys_tag_t head_tag_o,
    output logic      empty_o,

    // commit side
    input  logic      push_i,
    input  phys_tag_t push_tag_i,

    // head pointer checkpoint and restore
    output fl_ptr_t   head_ptr_o,
    input  logic      restore_i,
    input  fl_ptr_t   restore_ptr_i
);

    // at most PHYS_REGS-ARCH_REGS tags are ever free at once
    localparam int DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // ======================================================================
    // pointer helpers
    // ======================================================================

    // pointers run over two laps of the queue, 0 .. 2*DEPTH-1
    function automatic fl_ptr_t ptr_inc(input fl_ptr_t p);
        if (int'(p) == 2 * DEPTH - 1) begin
            return '0;
        end
        return p + fl_ptr_t'(1);
    endfunction

    // slot index, the lap is folded away
    function automatic idx_t ptr_idx(input fl_ptr_t p);
        if (int'(p) >= DEPTH) begin
            return idx_t'(int'(p) - DEPTH);
        end
        return idx_t'(p);
    endfunction

    // number of entries between head and tail
    function automatic cnt_t ptr_dist(input fl_ptr_t tl, input fl_ptr_t hd);
        int d;
        d = int'(tl) - int'(hd);
        if (d < 0) begin
            d = d + 2 * DEPTH;
        end
        return cnt_t'(d);
    endfunction

    // ======================================================================
    // queue
    // ======================================================================

    phys_tag_t queue [DEPTH];
    fl_ptr_t   head_ptr;
    fl_ptr_t   tail_ptr;
    fl_ptr_t   head_next;
    fl_ptr_t   tail_next;
    cnt_t      count;

    assign head_next = pop_i  ? ptr_inc(head_ptr) : head_ptr;
    assign tail_next = push_i ? ptr_inc(tail_ptr) : tail_ptr;

    always_ff @(posedge clock) begin
        if (reset) begin
            // full queue holding ARCH_REGS .. PHYS_REGS-1 in order
            for (int i = 0; i < DEPTH; i++) begin
                queue[i] <= phys_tag_t'(ARCH_REGS + i);
            end
            head_ptr <= '0;
            tail_ptr <= fl_ptr_t'(DEPTH);
            count    <= cnt_t'(DEPTH);
        end else begin
            if (push_i) begin
                queue[ptr_idx(tail_ptr)] <= push_tag_i;
            end
            tail_ptr <= tail_next;
            if (restore_i) begin
                // rewind head, this cycle's push is already in tail_next
                head_ptr <= restore_ptr_i;
                count    <= ptr_dist(tail_next, restore_ptr_i);
            end else begin
                head_ptr <= head_next;
                count    <= count + cnt_t'(push_i) - cnt_t'(pop_i);
            end
        end
    end

    assign head_tag_o = queue[ptr_idx(head_ptr)];
    assign empty_o    = (count == '0);
    assign head_ptr_o = head_ptr;

endmodule

//--- logic/map_table.sv
`timescale 1ns/1ps

module map_table import rename_pkg::*; #(
    parameter int ARCH_REGS = DEFAULT_ARCH_REGS,
    parameter int PHYS_REGS = DEFAULT_PHYS_REGS,
    parameter int WB_WIDTH  = DEFAULT_WB_WIDTH
) (
    input  logic                          clock,
    input  logic                          reset,

    // source lookups, combinational
    input  arch_reg_t                     rs1_arch_i,
    input  arch_reg_t                     rs2_arch_i,
    output phys_tag_t                     rs1_phys_o,
    output phys_tag_t                     rs2_phys_o,
    output logic                          rs1_ready_o,
    output logic                          rs2_ready_o,

    // destination rename
    input  logic                          rename_i,
    input  arch_reg_t                     rename_arch_i,
    input  phys_tag_t                     rename_phys_i,
    output phys_tag_t                     old_phys_o,

    // writeback ports
    input  logic      [WB_WIDTH-1:0]      wb_valid_i,
    input  phys_tag_t [WB_WIDTH-1:0]      wb_phys_i,

    // snapshot restore on mispredict
    input  logic                          restore_i,
    input  phys_tag_t [ARCH_REGS-1:0]     restore_phys_i,
    input  logic      [ARCH_REGS-1:0]     restore_ready_i,

    // live snapshot for the checkpoint store
    output phys_tag_t [ARCH_REGS-1:0]     snap_phys_o,
    output logic      [ARCH_REGS-1:0]     snap_ready_o
);

    // ======================================================================
    // state
    // ======================================================================

    // one tag and one ready bit per architectural register
    phys_tag_t [ARCH_REGS-1:0] map_phys;
    logic      [ARCH_REGS-1:0] map_ready;

    // entries whose tag is written back this cycle
    logic [ARCH_REGS-1:0] wb_hit;

    // ======================================================================
    // writeback match
    // ======================================================================

    // compare every entry against every writeback port
    always_comb begin
        wb_hit = '0;
        for (int j = 0; j < ARCH_REGS; j++) begin
            for (int k = 0; k < WB_WIDTH; k++) begin
                if (wb_valid_i[k] && (map_phys[j] == wb_phys_i[k])) begin
                    wb_hit[j] = 1'b1;
                end
            end
        end
    end

    // ======================================================================
    // table update
    // ======================================================================

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity mapping with every entry ready
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_phys[i]  <= phys_tag_t'(i);
                map_ready[i] <= 1'b1;
            end
        end else if (restore_i) begin
            // restore wins over a rename in the same cycle
            map_phys  <= restore_phys_i;
            map_ready <= restore_ready_i;
        end else begin
            // writebacks set ready bits except on the entry renamed now
            for (int j = 0; j < ARCH_REGS; j++) begin
                if (wb_hit[j] && !(rename_i && (rename_arch_i == arch_reg_t'(j)))) begin
                    map_ready[j] <= 1'b1;
                end
            end
            // new mapping starts not ready and register 0 stays put
            if (rename_i && (rename_arch_i != ZERO_REG)) begin
                map_phys[rename_arch_i]  <= rename_phys_i;
                map_ready[rename_arch_i] <= 1'b0;
            end
        end
    end

    // ======================================================================
    // lookups
    // ======================================================================

    // same-cycle writebacks are forwarded into the ready bits
    assign rs1_phys_o  = map_phys[rs1_arch_i];
    assign rs2_phys_o  = map_phys[rs2_arch_i];
    assign rs1_ready_o = map_ready[rs1_arch_i] | wb_hit[rs1_arch_i];
    assign rs2_ready_o = map_ready[rs2_arch_i] | wb_hit[rs2_arch_i];

    // prior tag of the destination goes back to the free list at commit
    assign old_phys_o = map_phys[rename_arch_i];

    // snapshot includes this cycle's writebacks
    // the table stores them at the same edge the checkpoint is captured
    assign snap_phys_o  = map_phys;
    assign snap_ready_o = map_ready | wb_hit;

endmodule

//--- logic/rename_pkg.sv
// ==========================================================================
// shared types and sizes for the rename stage
// ==========================================================================

package rename_pkg;

    // architectural register index, sized for 32 registers
    typedef logic [4:0] arch_reg_t;

    // physical register tag, sized for 64 physical registers
    typedef logic [5:0] phys_tag_t;

    // free-list pointer
    // one lap bit above the slot index, so full and empty differ
    typedef logic [5:0] fl_ptr_t;

    // register 0 reads as tag 0 forever and is never renamed
    localparam arch_reg_t ZERO_REG = 5'd0;

    // default sizes, the top level passes its own values down
    localparam int DEFAULT_ARCH_REGS = 32;
    localparam int DEFAULT_PHYS_REGS = 64;

    // default number of writeback ports
    localparam int DEFAULT_WB_WIDTH = 2;

    // single-branch checkpoint store
    // empty: nothing saved, a branch may dispatch
    // held:  one snapshot saved until resolve or mispredict
    typedef enum logic {
        CP_EMPTY,
        CP_HELD
    } cp_state_t;

endpackage

//--- logic/rename_unit.sv
`timescale 1ns/1ps

module rename_unit import rename_pkg::*; #(
    parameter int ARCH_REGS = DEFAULT_ARCH_REGS,
    parameter int PHYS_REGS = DEFAULT_PHYS_REGS,
    parameter int WB_WIDTH  = DEFAULT_WB_WIDTH
) (
    input  logic                          clock,
    input  logic                          reset,

    // dispatch handshake and fields
    input  logic                          disp_valid_i,
    output logic                          disp_ready_o,
    input  arch_reg_t                     disp_rd_i,
    input  arch_reg_t                     disp_rs1_i,
    input  arch_reg_t                     disp_rs2_i,
    input  logic                          disp_has_rd_i,
    input  logic                          disp_is_branch_i,

    // rename results, same cycle as dispatch
    output phys_tag_t                     rs1_phys_o,
    output phys_tag_t                     rs2_phys_o,
    output logic                          rs1_ready_o,
    output logic                          rs2_ready_o,
    output phys_tag_t                     rd_new_phys_o,
    output phys_tag_t                     rd_old_phys_o,

    // writeback
    input  logic      [WB_WIDTH-1:0]      wb_valid_i,
    input  phys_tag_t [WB_WIDTH-1:0]      wb_phys_i,

    // commit frees the old tag
    input  logic                          commit_valid_i,
    input  phys_tag_t                     commit_old_phys_i,

    // branch outcome
    input  logic                          resolve_i,
    input  logic                          mispredict_i
);

    // ======================================================================
    // control
    // ======================================================================

    logic                      fl_empty;
    phys_tag_t                 fl_head_tag;
    fl_ptr_t                   fl_head_ptr;
    logic                      cp_held;
    phys_tag_t [ARCH_REGS-1:0] snap_phys;
    logic      [ARCH_REGS-1:0] snap_ready;
    phys_tag_t [ARCH_REGS-1:0] saved_phys;
    logic      [ARCH_REGS-1:0] saved_ready;
    fl_ptr_t                   saved_ptr;
    logic                      needs_tag;
    logic                      accept;
    logic                      do_rename;
    logic                      take;

    // register 0 as destination allocates nothing
    assign needs_tag = disp_has_rd_i && (disp_rd_i != ZERO_REG);

    // stall on no free tag, a second branch, or a restore in progress
    assign disp_ready_o = !(needs_tag && fl_empty)
                       && !(disp_is_branch_i && cp_held)
                       && !mispredict_i;

    assign accept    = disp_valid_i && disp_ready_o;
    assign do_rename = accept && needs_tag;
    assign take      = accept && disp_is_branch_i;

    // new tag is the free-list head, valid only when allocating
    assign rd_new_phys_o = fl_head_tag;

    // ======================================================================
    // instances
    // ======================================================================

    map_table #(
        .ARCH_REGS (ARCH_REGS),
        .PHYS_REGS (PHYS_REGS),
        .WB_WIDTH  (WB_WIDTH)
    ) i_map_table (
        .clock           (clock),
        .reset           (reset),
        .rs1_arch_i      (disp_rs1_i),
        .rs2_arch_i      (disp_rs2_i),
        .rs1_phys_o      (rs1_phys_o),
        .rs2_phys_o      (rs2_phys_o),
        .rs1_ready_o     (rs1_ready_o),
        .rs2_ready_o     (rs2_ready_o),
        .rename_i        (do_rename),
        .rename_arch_i   (disp_rd_i),
        .rename_phys_i   (fl_head_tag),
        .old_phys_o      (rd_old_phys_o),
        .wb_valid_i      (wb_valid_i),
        .wb_phys_i       (wb_phys_i),
        .restore_i       (mispredict_i),
        .restore_phys_i  (saved_phys),
        .restore_ready_i (saved_ready),
        .snap_phys_o     (snap_phys),
        .snap_ready_o    (snap_ready)
    );

    free_list #(
        .ARCH_REGS (ARCH_REGS),
        .PHYS_REGS (PHYS_REGS)
    ) i_free_list (
        .clock         (clock),
        .reset         (reset),
        .pop_i         (do_rename),
        .head_tag_o    (fl_head_tag),
        .empty_o       (fl_empty),
        .push_i        (commit_valid_i),
        .push_tag_i    (commit_old_phys_i),
        .head_ptr_o    (fl_head_ptr),
        .restore_i     (mispredict_i),
        .restore_ptr_i (saved_ptr)
    );

    // mispredict both restores and frees the checkpoint
    checkpoint_store #(
        .ARCH_REGS (ARCH_REGS),
        .WB_WIDTH  (WB_WIDTH)
    ) i_checkpoint_store (
        .clock         (clock),
        .reset         (reset),
        .take_i        (take),
        .release_i     (resolve_i || mispredict_i),
        .snap_phys_i   (snap_phys),
        .snap_ready_i  (snap_ready),
        .head_ptr_i    (fl_head_ptr),
        .wb_valid_i    (wb_valid_i),
        .wb_phys_i     (wb_phys_i),
        .held_o        (cp_held),
        .saved_phys_o  (saved_phys),
        .saved_ready_o (saved_ready),
        .saved_ptr_o   (saved_ptr)
    );

endmodule

//--- run.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module rename_tb -f tb.f -o rename_sim
./obj_dir/rename_sim | tee sim.log
# the testbench prints the pass message on a line of its own
if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb.f
+incdir+verification
logic/rename_pkg.sv
logic/map_table.sv
logic/free_list.sv
logic/checkpoint_store.sv
logic/rename_unit.sv
verification/rename_tb.sv

//--- verification/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// ==========================================================================
// reference model of the rename stage
// ==========================================================================

// included inside rename_tb, after step_t and WB are declared

// architectural map and its ready bits
phys_tag_t ref_map [DEFAULT_ARCH_REGS];
logic      ref_rdy [DEFAULT_ARCH_REGS];

// every tag ever put in the free list, oldest first
// ref_head points at the next tag to allocate
phys_tag_t pushed_q [$];
int        ref_head;

// the one checkpoint
logic      cp_valid;
phys_tag_t cp_map [DEFAULT_ARCH_REGS];
logic      cp_rdy [DEFAULT_ARCH_REGS];
int        cp_head;

// old tags waiting for commit
// the last spec_cnt of them belong to renames after the held branch
phys_tag_t retire_q [$];
int        spec_cnt;

function automatic void reset_reference();
    for (int i = 0; i < DEFAULT_ARCH_REGS; i++) begin
        ref_map[i] = phys_tag_t'(i);
        ref_rdy[i] = 1'b1;
    end
    pushed_q.delete();
    for (int t = DEFAULT_ARCH_REGS; t < DEFAULT_PHYS_REGS; t++) begin
        pushed_q.push_back(phys_tag_t'(t));
    end
    ref_head = 0;
    cp_valid = 1'b0;
    cp_head  = 0;
    retire_q.delete();
    spec_cnt = 0;
endfunction

// true when any writeback port carries this tag in the step
function automatic logic written_back(input phys_tag_t tag, input step_t s);
    for (int k = 0; k < WB; k++) begin
        if (s.wb_v[k] && (s.wb_p[k] == tag)) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// fill the expected columns of one step, then advance the model by one edge
function automatic step_t predict_step(input step_t s_in);
    step_t s;
    logic  need_tag;
    logic  accept;
    s = s_in;
    need_tag  = s.d.has_rd && (s.d.rd != ZERO_REG);
    s.e_ready = !(need_tag && (ref_head == pushed_q.size()))
             && !(s.d.is_br && cp_valid)
             && !s.mispred;
    accept    = s.d.valid && s.e_ready;
    s.e_alloc = accept && need_tag;
    // lookups see this cycle's writebacks
    s.e_rs1_p = ref_map[s.d.rs1];
    s.e_rs1_r = ref_rdy[s.d.rs1] || written_back(ref_map[s.d.rs1], s);
    s.e_rs2_p = ref_map[s.d.rs2];
    s.e_rs2_r = ref_rdy[s.d.rs2] || written_back(ref_map[s.d.rs2], s);
    s.e_new   = s.e_alloc ? pushed_q[ref_head] : '0;
    s.e_old   = ref_map[s.d.rd];

    // writebacks land in the map and in a held checkpoint
    for (int j = 0; j < DEFAULT_ARCH_REGS; j++) begin
        if (written_back(ref_map[j], s)) begin
            ref_rdy[j] = 1'b1;
        end
        if (cp_valid && written_back(cp_map[j], s)) begin
            cp_rdy[j] = 1'b1;
        end
    end
    if (s.cm_v) begin
        pushed_q.push_back(s.cm_p);
    end

    if (s.mispred) begin
        // back to the branch, wrong-path old tags never commit
        ref_map  = cp_map;
        ref_rdy  = cp_rdy;
        ref_head = cp_head;
        for (int n = 0; n < spec_cnt; n++) begin
            void'(retire_q.pop_back());
        end
        spec_cnt = 0;
        cp_valid = 1'b0;
    end else if (s.resolve) begin
        spec_cnt = 0;
        cp_valid = 1'b0;
    end

    if (s.e_alloc) begin
        ref_map[s.d.rd] = pushed_q[ref_head];
        ref_rdy[s.d.rd] = 1'b0;
        ref_head++;
        retire_q.push_back(s.e_old);
        if (cp_valid) begin
            spec_cnt++;
        end
    end
    if (accept && s.d.is_br) begin
        cp_valid = 1'b1;
        cp_map   = ref_map;
        cp_rdy   = ref_rdy;
        cp_head  = ref_head;
    end
    return s;
endfunction

`endif

//--- verification/rename_tb.sv
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int WB           = DEFAULT_WB_WIDTH;
    localparam int RANDOM_STEPS = 160;

    // dispatch fields, held as one group while a dispatch is refused
    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      has_rd;
        logic      is_br;
    } disp_t;

    // one table row: stimulus first, then expected values (e_ prefix)
    typedef struct packed {
        disp_t              d;
        logic      [WB-1:0] wb_v;
        phys_tag_t [WB-1:0] wb_p;
        logic               cm_v;
        phys_tag_t          cm_p;
        logic               resolve;
        logic               mispred;
        logic               e_ready;
        phys_tag_t          e_rs1_p;
        logic               e_rs1_r;
        phys_tag_t          e_rs2_p;
        logic               e_rs2_r;
        logic               e_alloc;
        phys_tag_t          e_new;
        phys_tag_t          e_old;
    } step_t;

    `include "rename_model.svh"

    logic               clock;
    logic               reset;
    logic               disp_valid;
    logic               disp_ready;
    arch_reg_t          disp_rd;
    arch_reg_t          disp_rs1;
    arch_reg_t          disp_rs2;
    logic               disp_has_rd;
    logic               disp_is_branch;
    phys_tag_t          rs1_phys;
    phys_tag_t          rs2_phys;
    logic               rs1_ready;
    logic               rs2_ready;
    phys_tag_t          rd_new_phys;
    phys_tag_t          rd_old_phys;
    logic      [WB-1:0] wb_valid;
    phys_tag_t [WB-1:0] wb_phys;
    logic               commit_valid;
    phys_tag_t          commit_old_phys;
    logic               resolve;
    logic               mispredict;

    step_t       table_q [$];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          cycle_count;
    int          cycle_limit;

    rename_unit #(
        .ARCH_REGS (DEFAULT_ARCH_REGS),
        .PHYS_REGS (DEFAULT_PHYS_REGS),
        .WB_WIDTH  (WB)
    ) i_rename_unit (
        .clock             (clock),
        .reset             (reset),
        .disp_valid_i      (disp_valid),
        .disp_ready_o      (disp_ready),
        .disp_rd_i         (disp_rd),
        .disp_rs1_i        (disp_rs1),
        .disp_rs2_i        (disp_rs2),
        .disp_has_rd_i     (disp_has_rd),
        .disp_is_branch_i  (disp_is_branch),
        .rs1_phys_o        (rs1_phys),
        .rs2_phys_o        (rs2_phys),
        .rs1_ready_o       (rs1_ready),
        .rs2_ready_o       (rs2_ready),
        .rd_new_phys_o     (rd_new_phys),
        .rd_old_phys_o     (rd_old_phys),
        .wb_valid_i        (wb_valid),
        .wb_phys_i         (wb_phys),
        .commit_valid_i    (commit_valid),
        .commit_old_phys_i (commit_old_phys),
        .resolve_i         (resolve),
        .mispredict_i      (mispredict)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    // ======================================================================
    // table helpers
    // ======================================================================

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic step_t blank_step();
        step_t s;
        s = '0;
        return s;
    endfunction

    function automatic step_t dispatch_step(input arch_reg_t rd, input arch_reg_t rs1,
                                            input arch_reg_t rs2, input logic has_rd);
        step_t s;
        s          = '0;
        s.d.valid  = 1'b1;
        s.d.rd     = rd;
        s.d.rs1    = rs1;
        s.d.rs2    = rs2;
        s.d.has_rd = has_rd;
        return s;
    endfunction

    // commit the oldest old tag, never one from the wrong path
    function automatic step_t with_commit(input step_t s_in);
        step_t s;
        s = s_in;
        if (retire_q.size() > spec_cnt) begin
            s.cm_v = 1'b1;
            s.cm_p = retire_q.pop_front();
        end
        return s;
    endfunction

    task automatic append_step(input step_t s_in);
        step_t s;
        step_t prev;
        s = s_in;
        if (table_q.size() > 0) begin
            prev = table_q[$];
            // a refused dispatch stays on the bus unchanged
            if (prev.d.valid && !prev.e_ready) begin
                s.d = prev.d;
            end
        end
        table_q.push_back(predict_step(s));
    endtask

    // ======================================================================
    // stimulus table
    // ======================================================================

    task automatic build_table();
        step_t       s;
        step_t       br;
        logic [31:0] r;
        reset_reference();
        lcg_state = 32'h2f5c_ceb2;
        // identity map after reset, two registers per row
        for (int i = 0; i < DEFAULT_ARCH_REGS / 2; i++) begin
            s = blank_step();
            s.d.rs1 = arch_reg_t'(2 * i);
            s.d.rs2 = arch_reg_t'(2 * i + 1);
            append_step(s);
        end
        // first renames take 32, 33, 34
        append_step(dispatch_step(5'd5, 5'd5, 5'd6, 1'b1));
        append_step(dispatch_step(5'd6, 5'd5, 5'd6, 1'b1));
        append_step(dispatch_step(5'd5, 5'd5, 5'd6, 1'b1));
        // writebacks forwarded into the same lookup, then stored
        s = dispatch_step(5'd10, 5'd5, 5'd6, 1'b0);
        s.wb_v    = 2'b11;
        s.wb_p[0] = 6'd34;
        s.wb_p[1] = 6'd33;
        append_step(s);
        append_step(dispatch_step(5'd10, 5'd5, 5'd6, 1'b0));
        // x0 as destination allocates nothing
        append_step(dispatch_step(5'd0, 5'd0, 5'd5, 1'b1));
        append_step(dispatch_step(5'd7, 5'd0, 5'd7, 1'b1));
        // branch, wrong-path renames, a writeback, then mispredict
        br = dispatch_step(5'd0, 5'd7, 5'd5, 1'b0);
        br.d.is_br = 1'b1;
        append_step(br);
        append_step(dispatch_step(5'd8, 5'd8, 5'd7, 1'b1));
        append_step(dispatch_step(5'd5, 5'd5, 5'd8, 1'b1));
        s = blank_step();
        s.d.rs1   = 5'd7;
        s.wb_v    = 2'b01;
        s.wb_p[0] = 6'd35;
        append_step(s);
        s = dispatch_step(5'd9, 5'd5, 5'd7, 1'b1);
        s.mispred = 1'b1;
        append_step(s);
        append_step(dispatch_step(5'd9, 5'd5, 5'd7, 1'b1));
        append_step(dispatch_step(5'd10, 5'd8, 5'd9, 1'b0));
        // second branch waits until the first resolves
        append_step(br);
        append_step(br);
        s = br;
        s.resolve = 1'b1;
        append_step(s);
        append_step(br);
        s = blank_step();
        s.resolve = 1'b1;
        append_step(s);
        // drain the free list, refused dispatch waits for a commit
        for (int i = 0; i < 30; i++) begin
            append_step(dispatch_step(arch_reg_t'(1 + i % 31), arch_reg_t'(i), 5'd5, 1'b1));
        end
        for (int i = 0; i < 3; i++) begin
            append_step(with_commit(dispatch_step(5'd3, 5'd3, 5'd4, 1'b1)));
        end
        append_step(dispatch_step(5'd4, 5'd3, 5'd4, 1'b1));
        // random traffic
        for (int n = 0; n < RANDOM_STEPS; n++) begin
            r = next_random();
            s = blank_step();
            s.d.valid  = r[31];
            s.d.rd     = r[30:26];
            s.d.rs1    = r[25:21];
            s.d.rs2    = r[20:16];
            s.d.has_rd = r[15];
            s.d.is_br  = (r[14:12] == 3'd0);
            if (s.d.is_br) begin
                s.d.has_rd = 1'b0;
            end
            r = next_random();
            s.wb_v    = r[31:30];
            s.wb_p[0] = r[29:24];
            s.wb_p[1] = r[23:18];
            // branch outcome only while one is held
            if (cp_valid && (r[17:15] == 3'd0)) begin
                s.mispred = 1'b1;
            end else if (cp_valid && (r[17:15] == 3'd1)) begin
                s.resolve = 1'b1;
            end
            if (r[14:13] != 2'b00) begin
                s = with_commit(s);
            end
            append_step(s);
        end
    endtask

    // ======================================================================
    // drive and check
    // ======================================================================

    task automatic drive_inputs(input step_t s);
        disp_valid      = s.d.valid;
        disp_rd         = s.d.rd;
        disp_rs1        = s.d.rs1;
        disp_rs2        = s.d.rs2;
        disp_has_rd     = s.d.has_rd;
        disp_is_branch  = s.d.is_br;
        wb_valid        = s.wb_v;
        wb_phys         = s.wb_p;
        commit_valid    = s.cm_v;
        commit_old_phys = s.cm_p;
        resolve         = s.resolve;
        mispredict      = s.mispred;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    task automatic compare_outputs(input step_t e);
        check_value("disp_ready_o", 32'(disp_ready), 32'(e.e_ready));
        check_value("rs1_phys_o", 32'(rs1_phys), 32'(e.e_rs1_p));
        check_value("rs1_ready_o", 32'(rs1_ready), 32'(e.e_rs1_r));
        check_value("rs2_phys_o", 32'(rs2_phys), 32'(e.e_rs2_p));
        check_value("rs2_ready_o", 32'(rs2_ready), 32'(e.e_rs2_r));
        // new and old tag only mean something on an allocation
        if (e.e_alloc) begin
            check_value("rd_new_phys_o", 32'(rd_new_phys), 32'(e.e_new));
            check_value("rd_old_phys_o", 32'(rd_old_phys), 32'(e.e_old));
        end
    endtask

    initial begin
        reset       = 1'b1;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        drive_inputs(blank_step());
        build_table();
        cycle_limit = 4 * table_q.size() + 20;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        foreach (table_q[i]) begin
            drive_inputs(table_q[i]);
            // sample just before the rising edge
            #(CLK_PERIOD / 2 - 1);
            compare_outputs(table_q[i]);
            @(negedge clock);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

endmodule
